/* src/overlay_pkg.sv */
package overlay_pkg;

  //////////////////////////////////////////////////////////////////////
  // modes, geometry, register map

  typedef enum logic [1:0] {LOADING, READY, PLAY, FAIL} game_mode_t;

  // glyph cell in pixels
  localparam int char_w = 8;
  localparam int char_h = 8;

  // axi byte offsets
  localparam logic [3:0] reg_mode  = 4'h0;
  localparam logic [3:0] reg_score = 4'h4;
  localparam logic [3:0] reg_blink = 4'h8;

  //////////////////////////////////////////////////////////////////////
  // strings and their boxes, in cell units

  // centre message, shared by loading, ready and lost
  localparam int main_col    = 13;
  localparam int main_row    = 17;
  // press and restart prompts
  localparam int prompt_col  = 4;
  localparam int prompt_row  = 2;
  localparam int heading_col = 11;
  localparam int heading_row = 0;
  localparam int score_col   = 5;
  localparam int score_row   = 1;

  // widest string in bytes
  localparam int max_txt_len = 32;

  // first character sits in the top byte
  localparam logic [8*10-1:0] txt_loading = "LOADING...";
  localparam logic [8*6-1:0]  txt_ready   = "READY!";
  localparam logic [8*11-1:0] txt_lost    = "YOU LOST :(";
  localparam logic [8*23-1:0] txt_press   = "PRESS ANY KEY TO START!";
  localparam logic [8*25-1:0] txt_restart = "PRESS RESET TO PLAY AGAIN";
  localparam logic [8*10-1:0] txt_heading = "HIGH SCORE";

  //////////////////////////////////////////////////////////////////////
  // 8x8 font, row 0 in the top byte, column 0 its msb

  localparam int glyph_count = 41;

  localparam logic [63:0][63:0] glyph_table = '{
    // space, then 0..9
    0:  64'h0000_0000_0000_0000, 1:  64'h3c66_6e76_6666_3c00,
    2:  64'h1838_1818_1818_7e00, 3:  64'h3c66_060c_3060_7e00,
    4:  64'h3c66_061c_0666_3c00, 5:  64'h0c1c_3c6c_7e0c_0c00,
    6:  64'h7e60_7c06_0666_3c00, 7:  64'h3c60_7c66_6666_3c00,
    8:  64'h7e06_0c18_3030_3000, 9:  64'h3c66_663c_6666_3c00,
    10: 64'h3c66_663e_060c_3800,
    // A..Z
    11: 64'h183c_6666_7e66_6600, 12: 64'h7c66_667c_6666_7c00,
    13: 64'h3c66_6060_6066_3c00, 14: 64'h786c_6666_666c_7800,
    15: 64'h7e60_607c_6060_7e00, 16: 64'h7e60_607c_6060_6000,
    17: 64'h3c66_606e_6666_3c00, 18: 64'h6666_667e_6666_6600,
    19: 64'h3c18_1818_1818_3c00, 20: 64'h1e0c_0c0c_0c6c_3800,
    21: 64'h666c_7870_786c_6600, 22: 64'h6060_6060_6060_7e00,
    23: 64'h6377_7f6b_6363_6300, 24: 64'h6676_7e7e_6e66_6600,
    25: 64'h3c66_6666_6666_3c00, 26: 64'h7c66_667c_6060_6000,
    27: 64'h3c66_6666_663c_0e00, 28: 64'h7c66_667c_786c_6600,
    29: 64'h3c66_603c_0666_3c00, 30: 64'h7e18_1818_1818_1800,
    31: 64'h6666_6666_6666_3c00, 32: 64'h6666_6666_663c_1800,
    33: 64'h6363_636b_7f77_6300, 34: 64'h6666_3c18_3c66_6600,
    35: 64'h6666_663c_1818_1800, 36: 64'h7e06_0c18_3060_7e00,
    // . ! : (
    37: 64'h0000_0000_0018_1800, 38: 64'h1818_1818_0000_1800,
    39: 64'h0018_1800_1818_0000, 40: 64'h0c18_3030_3018_0c00,
    default: 64'h0
  };

  // ascii to glyph index, anything unknown draws as space
  function automatic logic [5:0] glyph_code(input logic [7:0] ascii);
    if (ascii >= "0" && ascii <= "9") return 6'(ascii - 8'd47);
    if (ascii >= "A" && ascii <= "Z") return 6'(ascii - 8'd54);
    case (ascii)
      ".": return 6'd37;
      "!": return 6'd38;
      ":": return 6'd39;
      "(": return 6'd40;
      default: return 6'd0;
    endcase
  endfunction

  // character of txt under cell cx, cy; zero outside its box
  function automatic logic [7:0] cell_char(input logic [8*max_txt_len-1:0] txt,
                                           input int col, input int row,
                                           input int cx, input int cy);
    int len;
    len = 0;
    // string is right aligned, zero bytes above it
    for (int i = 0; i < max_txt_len; i++) begin
      if (txt[8*i +: 8] != 8'h00) len = i + 1;
    end
    if (cy != row || cx < col || cx >= col + len) return 8'h00;
    return txt[8*(len - 1 - (cx - col)) +: 8];
  endfunction

endpackage

/* src/overlay_cfg_if.sv */
interface overlay_cfg_if #(
  parameter int score_w     = 16,
  parameter int blink_cnt_w = 24
);

  overlay_pkg::game_mode_t mode;
  // raw binary score, converted downstream
  logic [score_w-1:0]      score;
  // half-period in clocks, zero keeps blinking text steady
  logic [blink_cnt_w-1:0]  blink_half;
  // one cycle per write of the blink register
  logic                    blink_restart;

  // register block side
  modport source (output mode, score, blink_half, blink_restart);
  // overlay side
  modport sink (input mode, score, blink_half, blink_restart);

endinterface

/* src/overlay_regs.sv */
module overlay_regs #(
  parameter int score_w     = 16,
  parameter int blink_cnt_w = 24
) (
  input  logic          clk,
  input  logic          rst_n,
  // write address and data, taken together
  input  logic [3:0]    awaddr,
  input  logic          awvalid,
  output logic          awready,
  input  logic [31:0]   wdata,
  input  logic [3:0]    wstrb,
  input  logic          wvalid,
  output logic          wready,
  output logic [1:0]    bresp,
  output logic          bvalid,
  input  logic          bready,
  // read
  input  logic [3:0]    araddr,
  input  logic          arvalid,
  output logic          arready,
  output logic [31:0]   rdata,
  output logic [1:0]    rresp,
  output logic          rvalid,
  input  logic          rready,
  overlay_cfg_if.source cfg
);

  overlay_pkg::game_mode_t mode_q;
  logic [score_w-1:0]      score_q;
  logic [blink_cnt_w-1:0]  blink_q;
  logic                    restart_q;
  logic [31:0]             mode_word;
  logic [31:0]             score_word;
  logic [31:0]             blink_word;
  logic [31:0]             mode_new;
  logic [31:0]             score_new;
  logic [31:0]             blink_new;
  logic [31:0]             rd_word;
  logic                    wr_ok;
  logic                    wr_fire;
  logic                    rd_fire;

  // strobed bytes replace the old ones
  function automatic logic [31:0] byte_merge(input logic [31:0] old_word,
                                             input logic [31:0] new_word,
                                             input logic [3:0]  strb);
    logic [31:0] res;
    res = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) res[8*i +: 8] = new_word[8*i +: 8];
    end
    return res;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // handshakes

  // aw and w only when both are there, or both idle
  assign wr_ok   = !bvalid && (awvalid == wvalid);
  assign awready = wr_ok;
  assign wready  = wr_ok;
  assign wr_fire = wr_ok && awvalid;
  assign arready = !rvalid;
  assign rd_fire = arvalid && !rvalid;

  // always OKAY
  assign bresp = 2'b00;
  assign rresp = 2'b00;

  // zero-extended views, used for read-back and merge
  assign mode_word  = 32'(mode_q);
  assign score_word = 32'(score_q);
  assign blink_word = 32'(blink_q);
  assign mode_new   = byte_merge(mode_word, wdata, wstrb);
  assign score_new  = byte_merge(score_word, wdata, wstrb);
  assign blink_new  = byte_merge(blink_word, wdata, wstrb);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mode_q    <= overlay_pkg::LOADING;
      score_q   <= '0;
      blink_q   <= '0;
      restart_q <= 1'b0;
      bvalid    <= 1'b0;
    end else begin
      restart_q <= 1'b0;
      if (bvalid && bready) bvalid <= 1'b0;
      if (wr_fire) begin
        bvalid <= 1'b1;
        case (awaddr)
          overlay_pkg::reg_mode:  mode_q  <= overlay_pkg::game_mode_t'(mode_new[1:0]);
          overlay_pkg::reg_score: score_q <= score_new[score_w-1:0];
          overlay_pkg::reg_blink: begin
            blink_q   <= blink_new[blink_cnt_w-1:0];
            restart_q <= 1'b1;
          end
          // unmapped, data dropped
          default: ;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read path

  always_comb begin
    case (araddr)
      overlay_pkg::reg_mode:  rd_word = mode_word;
      overlay_pkg::reg_score: rd_word = score_word;
      overlay_pkg::reg_blink: rd_word = blink_word;
      default:                rd_word = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
    end else if (rd_fire) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) rdata <= rd_word;
  end

  assign cfg.mode          = mode_q;
  assign cfg.score         = score_q;
  assign cfg.blink_half    = blink_q;
  assign cfg.blink_restart = restart_q;

  // responses held until the host takes them
  a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid);
  a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

/* src/blink_timer.sv */
module blink_timer #(
  parameter int cnt_w = 24
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [cnt_w-1:0] half_period,
  input  logic             restart,
  output logic             phase
);

  logic [cnt_w-1:0] cnt;

  // phase flips every half_period clocks
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt   <= '0;
      phase <= 1'b0;
    end else if (restart || half_period == '0) begin
      // restart, or blinking off, parks on low phase
      cnt   <= '0;
      phase <= 1'b0;
    end else if (cnt >= half_period - 1'b1) begin
      // >= covers a period shortened mid-count
      cnt   <= '0;
      phase <= ~phase;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

/* src/score_bcd.sv */
module score_bcd #(
  parameter int score_w = 16
) (
  input  logic [score_w-1:0] binary,
  // digits[3] is the thousands
  output logic [3:0][3:0]    digits
);

  localparam int max_score = 9999;

  logic [score_w-1:0] sat;
  logic [15:0]        bcd;

  // clamp to four digits
  assign sat = (binary > max_score) ? score_w'(max_score) : binary;

  //////////////////////////////////////////////////////////////////////
  // double dabble, msb first

  always_comb begin
    bcd = '0;
    for (int i = score_w - 1; i >= 0; i--) begin
      // add 3 to any digit of 5 or more before the shift
      for (int d = 0; d < 4; d++) begin
        if (bcd[4*d +: 4] >= 4'd5) bcd[4*d +: 4] = bcd[4*d +: 4] + 4'd3;
      end
      bcd = {bcd[14:0], sat[i]};
    end
  end

  // clamped value never overflows 16 bcd bits
  assign digits = bcd;

endmodule

/* src/glyph_rom.sv */
module glyph_rom (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic [5:0]                            code,
  input  logic [$clog2(overlay_pkg::char_h)-1:0] row,
  input  logic [$clog2(overlay_pkg::char_w)-1:0] col,
  output logic                                  pixel
);

  logic [5:0]                             code_q;
  logic [$clog2(overlay_pkg::char_h)-1:0] row_q;
  logic [$clog2(overlay_pkg::char_w)-1:0] col_q;
  logic [63:0]                            bits;

  // address stage, first pixel cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      code_q <= '0;
      row_q  <= '0;
      col_q  <= '0;
    end else begin
      code_q <= code;
      row_q  <= row;
      col_q  <= col;
    end
  end

  assign bits = overlay_pkg::glyph_table[code_q];

  // top row in the top byte, leftmost column in its msb
  assign pixel = bits[overlay_pkg::char_w * overlay_pkg::char_h - 1
                      - (int'(row_q) * overlay_pkg::char_w + int'(col_q))];

  // only glyphs the font defines
  a_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
    code_q < overlay_pkg::glyph_count);

endmodule

/* src/text_overlay.sv */
module text_overlay #(
  parameter int score_w     = 16,
  parameter int blink_cnt_w = 24
) (
  input  logic        clk,
  input  logic        rst_n,
  overlay_cfg_if.sink cfg,
  input  logic [7:0]  sx,
  input  logic [8:0]  sy,
  output logic [3:0]  r,
  output logic [3:0]  g,
  output logic [3:0]  b
);

  logic            phase;
  logic [3:0][3:0] digits;
  logic [31:0]     score_txt;
  int              cx;
  int              cy;
  logic [7:0]      hit;
  logic            pixel;

  blink_timer #(
    .cnt_w (blink_cnt_w)
  ) u_blink (
    .clk         (clk),
    .rst_n       (rst_n),
    .half_period (cfg.blink_half),
    .restart     (cfg.blink_restart),
    .phase       (phase)
  );

  score_bcd #(
    .score_w (score_w)
  ) u_bcd (
    .binary (cfg.score),
    .digits (digits)
  );

  // digits as ascii, thousands in the top byte
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      score_txt[8*i +: 8] = 8'h30 + 8'(digits[i]);
    end
  end

  // cell under the beam
  assign cx = int'(sx) / overlay_pkg::char_w;
  assign cy = int'(sy) / overlay_pkg::char_h;

  //////////////////////////////////////////////////////////////////////
  // string select per mode

  // boxes never overlap, so hits can be or-ed
  always_comb begin
    hit = 8'h00;
    case (cfg.mode)
      overlay_pkg::LOADING: begin
        hit = overlay_pkg::cell_char(overlay_pkg::txt_loading, overlay_pkg::main_col,
                                     overlay_pkg::main_row, cx, cy);
      end
      overlay_pkg::READY: begin
        // ready text on low phase, press prompt on high
        if (phase) begin
          hit = overlay_pkg::cell_char(overlay_pkg::txt_press, overlay_pkg::prompt_col,
                                       overlay_pkg::prompt_row, cx, cy);
        end else begin
          hit = overlay_pkg::cell_char(overlay_pkg::txt_ready, overlay_pkg::main_col,
                                       overlay_pkg::main_row, cx, cy);
        end
      end
      default: begin
        // play and fail both show heading and score
        hit = overlay_pkg::cell_char(overlay_pkg::txt_heading, overlay_pkg::heading_col,
                                     overlay_pkg::heading_row, cx, cy)
            | overlay_pkg::cell_char(score_txt, overlay_pkg::score_col,
                                     overlay_pkg::score_row, cx, cy);
        if (cfg.mode == overlay_pkg::FAIL) begin
          hit |= overlay_pkg::cell_char(overlay_pkg::txt_lost, overlay_pkg::main_col,
                                        overlay_pkg::main_row, cx, cy);
          // restart prompt blinks, low phase only
          if (!phase) begin
            hit |= overlay_pkg::cell_char(overlay_pkg::txt_restart, overlay_pkg::prompt_col,
                                          overlay_pkg::prompt_row, cx, cy);
          end
        end
      end
    endcase
  end

  // no hit is byte 0, which draws as space
  glyph_rom u_rom (
    .clk   (clk),
    .rst_n (rst_n),
    .code  (overlay_pkg::glyph_code(hit)),
    .row   (sy[$clog2(overlay_pkg::char_h)-1:0]),
    .col   (sx[$clog2(overlay_pkg::char_w)-1:0]),
    .pixel (pixel)
  );

  // colour stage, white on black
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      r <= '0;
      g <= '0;
      b <= '0;
    end else begin
      r <= {4{pixel}};
      g <= {4{pixel}};
      b <= {4{pixel}};
    end
  end

endmodule

/* src/overlay_top.sv */
module overlay_top #(
  parameter int blink_cnt_w = 24,
  parameter int score_w     = 16
) (
  input  logic        clk,
  input  logic        rst_n,
  // axi4-lite slave
  input  logic [3:0]  awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  input  logic [3:0]  araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready,
  // pixel in, colour two clocks later
  input  logic [7:0]  sx,
  input  logic [8:0]  sy,
  output logic [3:0]  r,
  output logic [3:0]  g,
  output logic [3:0]  b
);

  overlay_cfg_if #(
    .score_w     (score_w),
    .blink_cnt_w (blink_cnt_w)
  ) cfg_bus ();

  overlay_regs #(
    .score_w     (score_w),
    .blink_cnt_w (blink_cnt_w)
  ) u_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .cfg     (cfg_bus)
  );

  text_overlay #(
    .score_w     (score_w),
    .blink_cnt_w (blink_cnt_w)
  ) u_overlay (
    .clk   (clk),
    .rst_n (rst_n),
    .cfg   (cfg_bus),
    .sx    (sx),
    .sy    (sy),
    .r     (r),
    .g     (g),
    .b     (b)
  );

endmodule

/* bench/overlay_tb.sv */
module overlay_tb;
  timeunit 1ns;
  timeprecision 100ps;

  // cycles any handshake wait may take
  localparam int timeout_cycles = 50;

  logic        clk;
  logic        rst_n;
  logic [3:0]  awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [3:0]  araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;
  logic [7:0]  sx;
  logic [8:0]  sy;
  logic [3:0]  r;
  logic [3:0]  g;
  logic [3:0]  b;

  int   checks;
  int   errors;
  int   test_errors;
  // blink phases seen on the screen
  logic seen_low;
  logic seen_high;

  overlay_top UUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready),
    .sx      (sx),
    .sy      (sy),
    .r       (r),
    .g       (g),
    .b       (b)
  );

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // checking and reporting

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      test_errors++;
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic report_test(input string name);
    $display("test %s finished, %0d mismatches", name, test_errors);
    test_errors = 0;
  endtask

  task automatic give_up(input string what);
    $display("timeout while waiting for %s", what);
    $display("Done: errors found");
    $finish;
  endtask

  //////////////////////////////////////////////////////////////////////
  // screen model

  // char of a right-aligned string inside its box, zero elsewhere
  function automatic logic [7:0] box_char(input logic [255:0] txt, input int len,
                                          input int col, input int row,
                                          input int cx, input int cy);
    if (cy != row || cx < col || cx >= col + len) return 8'h00;
    // first char sits in the top byte
    return txt[8 * (len - 1 - (cx - col)) +: 8];
  endfunction

  // four decimal digits, clamped at 9999
  function automatic logic [31:0] score_text(input int unsigned score);
    int unsigned v;
    v = (score > 9999) ? 9999 : score;
    return {8'h30 + 8'(v / 1000), 8'h30 + 8'((v / 100) % 10),
            8'h30 + 8'((v / 10) % 10), 8'h30 + 8'(v % 10)};
  endfunction

  function automatic logic [7:0] screen_char(input overlay_pkg::game_mode_t mode,
                                             input int unsigned score, input logic phase,
                                             input int cx, input int cy);
    logic [7:0] ch;
    ch = 8'h00;
    case (mode)
      overlay_pkg::LOADING: begin
        ch = box_char(overlay_pkg::txt_loading, $bits(overlay_pkg::txt_loading) / 8,
                      overlay_pkg::main_col, overlay_pkg::main_row, cx, cy);
      end
      overlay_pkg::READY: begin
        // ready text on low phase, press prompt on high
        if (phase) begin
          ch = box_char(overlay_pkg::txt_press, $bits(overlay_pkg::txt_press) / 8,
                        overlay_pkg::prompt_col, overlay_pkg::prompt_row, cx, cy);
        end else begin
          ch = box_char(overlay_pkg::txt_ready, $bits(overlay_pkg::txt_ready) / 8,
                        overlay_pkg::main_col, overlay_pkg::main_row, cx, cy);
        end
      end
      default: begin
        ch = box_char(overlay_pkg::txt_heading, $bits(overlay_pkg::txt_heading) / 8,
                      overlay_pkg::heading_col, overlay_pkg::heading_row, cx, cy);
        if (ch == 8'h00) begin
          ch = box_char(score_text(score), 4, overlay_pkg::score_col,
                        overlay_pkg::score_row, cx, cy);
        end
        if (mode == overlay_pkg::FAIL && ch == 8'h00) begin
          ch = box_char(overlay_pkg::txt_lost, $bits(overlay_pkg::txt_lost) / 8,
                        overlay_pkg::main_col, overlay_pkg::main_row, cx, cy);
        end
        // restart prompt only on low phase
        if (mode == overlay_pkg::FAIL && ch == 8'h00 && !phase) begin
          ch = box_char(overlay_pkg::txt_restart, $bits(overlay_pkg::txt_restart) / 8,
                        overlay_pkg::prompt_col, overlay_pkg::prompt_row, cx, cy);
        end
      end
    endcase
    return ch;
  endfunction

  function automatic logic [11:0] expected_colour(input overlay_pkg::game_mode_t mode,
                                                  input int unsigned score, input logic phase,
                                                  input int x, input int y);
    logic [7:0]  ch;
    logic [63:0] bits;
    ch   = screen_char(mode, score, phase, x / overlay_pkg::char_w, y / overlay_pkg::char_h);
    bits = overlay_pkg::glyph_table[overlay_pkg::glyph_code(ch)];
    // row 0 top byte, column 0 its msb
    if (bits[63 - (y % overlay_pkg::char_h) * overlay_pkg::char_w - x % overlay_pkg::char_w])
      return 12'hfff;
    return 12'h000;
  endfunction

  function automatic logic [31:0] byte_update(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0] strb);
    logic [31:0] w;
    w = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) w[8*i +: 8] = new_word[8*i +: 8];
    end
    return w;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // axi4-lite host, entered 1 ns after a rising edge

  task automatic axi_write(input string name, input logic [3:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input int hold);
    int wait_cnt;
    awaddr   = addr;
    awvalid  = 1'b1;
    wdata    = data;
    wstrb    = strb;
    wvalid   = 1'b1;
    wait_cnt = 0;
    // ready looked at mid-cycle, transfer on the next edge
    @(negedge clk);
    while (!(awready && wready)) begin
      wait_cnt++;
      if (wait_cnt > timeout_cycles) give_up("awready and wready");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    awvalid  = 1'b0;
    wvalid   = 1'b0;
    wait_cnt = 0;
    while (!bvalid) begin
      wait_cnt++;
      if (wait_cnt > timeout_cycles) give_up("bvalid");
      @(posedge clk);
      #1;
    end
    check({name, " bresp"}, 32'h0, 32'(bresp));
    // response must stay up while bready is low
    repeat (hold) begin
      @(posedge clk);
      #1;
      check({name, " bvalid held"}, 32'h1, 32'(bvalid));
    end
    bready = 1'b1;
    @(posedge clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic axi_read(input string name, input logic [3:0] addr, input int hold,
                          output logic [31:0] data);
    int wait_cnt;
    araddr   = addr;
    arvalid  = 1'b1;
    wait_cnt = 0;
    @(negedge clk);
    while (!arready) begin
      wait_cnt++;
      if (wait_cnt > timeout_cycles) give_up("arready");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    arvalid  = 1'b0;
    wait_cnt = 0;
    while (!rvalid) begin
      wait_cnt++;
      if (wait_cnt > timeout_cycles) give_up("rvalid");
      @(posedge clk);
      #1;
    end
    data = rdata;
    check({name, " rresp"}, 32'h0, 32'(rresp));
    repeat (hold) begin
      @(posedge clk);
      #1;
      check({name, " rvalid held"}, 32'h1, 32'(rvalid));
      check({name, " rdata held"}, data, rdata);
    end
    rready = 1'b1;
    @(posedge clk);
    #1;
    rready = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // pixel stream, one per clock, colour two clocks later

  // area 0 whole screen, 1 score digits, 2 ready and prompt boxes
  task automatic run_pixels(input string name, input int n, input int area,
                            input overlay_pkg::game_mode_t mode, input int unsigned score,
                            input bit blinking);
    logic [23:0] exp_q[$];
    logic [23:0] pair;
    logic [11:0] lo;
    logic [11:0] hi;
    logic [11:0] act;
    int          rows[4];
    int          x;
    int          y;
    rows[0] = overlay_pkg::heading_row;
    rows[1] = overlay_pkg::score_row;
    rows[2] = overlay_pkg::prompt_row;
    rows[3] = overlay_pkg::main_row;
    for (int i = 0; i < n + 2; i++) begin
      @(posedge clk);
      #1;
      if (i >= 2) begin
        pair = exp_q.pop_front();
        lo   = pair[23:12];
        hi   = pair[11:0];
        act  = {r, g, b};
        if (lo != hi && act == lo) seen_low = 1'b1;
        if (lo != hi && act == hi) seen_high = 1'b1;
        check(name, (act == hi) ? 32'(hi) : 32'(lo), 32'(act));
      end
      if (i < n) begin
        case (area)
          0: begin
            x = $urandom % 256;
            // half on the text rows, half anywhere
            if ($urandom % 2) y = $urandom % 512;
            else y = rows[$urandom % 4] * overlay_pkg::char_h + $urandom % 8;
          end
          1: begin
            x = overlay_pkg::score_col * overlay_pkg::char_w + $urandom % 32;
            y = overlay_pkg::score_row * overlay_pkg::char_h + $urandom % 8;
          end
          default: begin
            // string width in pixels equals its bit count
            if ($urandom % 2) begin
              x = overlay_pkg::prompt_col * 8 + $urandom % $bits(overlay_pkg::txt_press);
              y = overlay_pkg::prompt_row * 8 + $urandom % 8;
            end else begin
              x = overlay_pkg::main_col * 8 + $urandom % $bits(overlay_pkg::txt_ready);
              y = overlay_pkg::main_row * 8 + $urandom % 8;
            end
          end
        endcase
        sx = 8'(x);
        sy = 9'(y);
        lo = expected_colour(mode, score, 1'b0, x, y);
        hi = blinking ? expected_colour(mode, score, 1'b1, x, y) : lo;
        exp_q.push_back({lo, hi});
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence

  initial begin
    logic [31:0] rd;
    logic [31:0] data;
    logic [31:0] exp_rd;
    logic [31:0] sh_mode;
    logic [31:0] sh_score;
    logic [31:0] sh_blink;
    logic [3:0]  addr;
    logic [3:0]  strb;
    int unsigned score;
    void'($urandom(32'h286a_ac59));
    checks      = 0;
    errors      = 0;
    test_errors = 0;
    seen_low    = 1'b0;
    seen_high   = 1'b0;
    rst_n       = 1'b0;
    awaddr      = '0;
    awvalid     = 1'b0;
    wdata       = '0;
    wstrb       = '0;
    wvalid      = 1'b0;
    bready      = 1'b0;
    araddr      = '0;
    arvalid     = 1'b0;
    rready      = 1'b0;
    sx          = '0;
    sy          = '0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // idle bus and dark screen out of reset
    check("reset awready", 32'h1, 32'(awready));
    check("reset wready", 32'h1, 32'(wready));
    check("reset arready", 32'h1, 32'(arready));
    check("reset bvalid", 32'h0, 32'(bvalid));
    check("reset rvalid", 32'h0, 32'(rvalid));
    check("reset colour", 32'h0, 32'({r, g, b}));
    report_test("reset_values");

    // register map with shadow copies
    sh_mode  = 32'h0;
    sh_score = 32'h0;
    sh_blink = 32'h0;
    for (int i = 0; i < 40; i++) begin
      data = $urandom;
      strb = ($urandom % 3 == 0) ? 4'($urandom) : 4'hf;
      case ($urandom % 4)
        0: begin
          addr    = overlay_pkg::reg_mode;
          sh_mode = byte_update(sh_mode, data, strb) & 32'h3;
          exp_rd  = sh_mode;
        end
        1: begin
          addr     = overlay_pkg::reg_score;
          sh_score = byte_update(sh_score, data, strb) & 32'hffff;
          exp_rd   = sh_score;
        end
        2: begin
          addr     = overlay_pkg::reg_blink;
          sh_blink = byte_update(sh_blink, data, strb) & 32'hff_ffff;
          exp_rd   = sh_blink;
        end
        default: begin
          // unmapped offsets, aligned or not
          addr   = ($urandom % 2) ? 4'hc : 4'(4 * ($urandom % 4) + 1 + $urandom % 3);
          exp_rd = 32'h0;
        end
      endcase
      axi_write("reg_write", addr, data, strb, 0);
      axi_read("reg_read", addr, 0, rd);
      check("reg_readback", exp_rd, rd);
    end
    axi_read("reg_read", overlay_pkg::reg_mode, 0, rd);
    check("reg_final_mode", sh_mode, rd);
    axi_read("reg_read", overlay_pkg::reg_score, 0, rd);
    check("reg_final_score", sh_score, rd);
    axi_read("reg_read", overlay_pkg::reg_blink, 0, rd);
    check("reg_final_blink", sh_blink, rd);
    report_test("register_access");

    // each mode, blinking text held on low phase
    axi_write("cfg_write", overlay_pkg::reg_blink, 32'h0, 4'hf, 0);
    for (int m = 0; m < 4; m++) begin
      score = $urandom % 20000;
      axi_write("cfg_write", overlay_pkg::reg_score, score, 4'hf, 0);
      axi_write("cfg_write", overlay_pkg::reg_mode, m, 4'hf, 0);
      run_pixels($sformatf("mode_text_%0d", m), 300, 0,
                 overlay_pkg::game_mode_t'(m), score, 1'b0);
    end
    report_test("mode_text");

    // score digits, some past 9999
    axi_write("cfg_write", overlay_pkg::reg_mode, overlay_pkg::PLAY, 4'hf, 0);
    for (int i = 0; i < 12; i++) begin
      score = (i % 3 == 0) ? 10000 + $urandom % 55536 : $urandom % 10000;
      axi_write("cfg_write", overlay_pkg::reg_score, score, 4'hf, 0);
      run_pixels("score_digits", 80, 1, overlay_pkg::PLAY, score, 1'b0);
    end
    report_test("score");

    // short half-period, either screen is fine per pixel
    axi_write("cfg_write", overlay_pkg::reg_mode, overlay_pkg::READY, 4'hf, 0);
    axi_write("cfg_write", overlay_pkg::reg_blink, 32'h4, 4'hf, 0);
    seen_low  = 1'b0;
    seen_high = 1'b0;
    run_pixels("blink_pixel", 400, 2, overlay_pkg::READY, 0, 1'b1);
    check("blink_low_phase_seen", 32'h1, 32'(seen_low));
    check("blink_high_phase_seen", 32'h1, 32'(seen_high));
    axi_write("cfg_write", overlay_pkg::reg_blink, 32'h0, 4'hf, 0);
    report_test("blink");

    // stalled responses, then the next access
    for (int i = 0; i < 8; i++) begin
      data = $urandom % 65536;
      axi_write("bp_write", overlay_pkg::reg_score, data, 4'hf, 1 + $urandom % 6);
      axi_read("bp_read", overlay_pkg::reg_score, 1 + $urandom % 6, rd);
      check("bp_data", data, rd);
    end
    report_test("back_pressure");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* filelist.f */
src/overlay_pkg.sv
src/overlay_cfg_if.sv
src/overlay_regs.sv
src/blink_timer.sv
src/score_bcd.sv
src/glyph_rom.sv
src/text_overlay.sv
src/overlay_top.sv
bench/overlay_tb.sv
